/* Bender.yml */
package:
  name: ttc_timer

sources:
  - hdl/ttc_reg_pkg.sv
  - hdl/ttc_irq_pkg.sv
  - hdl/ttc_cfg_if.sv
  - hdl/ttc_reg_decode.sv
  - hdl/ttc_prescaler.sv
  - hdl/ttc_counter_lite.sv
  - hdl/ttc_intr_wave.sv
  - hdl/ttc_timer_top.sv
  - target: test
    files:
      - tb/ttc_timer_checker.sv
      - tb/ttc_timer_tb.sv

/* hdl/ttc_cfg_if.sv */
// ------------------------------
// Decode to counter link: write
// data, select strobes, readback
// ------------------------------
interface ttc_cfg_if;

  logic [ttc_reg_pkg::data_w-1:0] wdata;  // Bus write data

  // One cycle write strobes
  logic cntr_ctrl_sel;
  logic interval_sel;
  logic match_1_sel;
  logic match_2_sel;
  logic match_3_sel;

  // Register readback
  logic [ttc_reg_pkg::ctrl_w-1:0] cntr_ctrl_out;
  logic [ttc_reg_pkg::data_w-1:0] interval_out;
  logic [ttc_reg_pkg::data_w-1:0] match_1_out;
  logic [ttc_reg_pkg::data_w-1:0] match_2_out;
  logic [ttc_reg_pkg::data_w-1:0] match_3_out;
  logic [ttc_reg_pkg::data_w-1:0] count_out;

  modport decode (
    output wdata, cntr_ctrl_sel, interval_sel, match_1_sel, match_2_sel, match_3_sel,
    input  cntr_ctrl_out, interval_out, match_1_out, match_2_out, match_3_out, count_out
  );

  modport counter (
    input  wdata, cntr_ctrl_sel, interval_sel, match_1_sel, match_2_sel, match_3_sel,
    output cntr_ctrl_out, interval_out, match_1_out, match_2_out, match_3_out, count_out
  );

endinterface

/* hdl/ttc_counter_lite.sv */
// ------------------------------
// Timer counter: control, interval
// and match registers, raw events
// ------------------------------
module ttc_counter_lite (
  input  logic                          pclk10,
  input  logic                          n_p_reset10,
  ttc_cfg_if.counter                    cfg,
  input  logic                          count_en,   // From prescaler
  output logic [ttc_irq_pkg::irq_n-1:0] raw_irq,
  output logic                          wave_dis,
  output logic                          wave_pol
);

  logic [ttc_reg_pkg::ctrl_w-1:0] cntr_ctrl;
  logic [ttc_reg_pkg::data_w-1:0] interval;
  logic [ttc_reg_pkg::data_w-1:0] match_1;
  logic [ttc_reg_pkg::data_w-1:0] match_2;
  logic [ttc_reg_pkg::data_w-1:0] match_3;
  logic [ttc_reg_pkg::data_w-1:0] count;

  logic counting;      // Set once a step has been taken
  logic restart_done;  // Pulse after a restart load
  logic dis;
  logic intv;
  logic decr;
  logic match_md;
  logic restart;
  logic live;          // Events may be flagged

  assign dis      = cntr_ctrl[ttc_reg_pkg::ctrl_dis];
  assign intv     = cntr_ctrl[ttc_reg_pkg::ctrl_interval];
  assign decr     = cntr_ctrl[ttc_reg_pkg::ctrl_decr];
  assign match_md = cntr_ctrl[ttc_reg_pkg::ctrl_match];
  assign restart  = cntr_ctrl[ttc_reg_pkg::ctrl_restart];
  assign wave_dis = cntr_ctrl[ttc_reg_pkg::ctrl_wave_dis];
  assign wave_pol = cntr_ctrl[ttc_reg_pkg::ctrl_wave_pol];

  // Readback
  assign cfg.cntr_ctrl_out = cntr_ctrl;
  assign cfg.interval_out  = interval;
  assign cfg.match_1_out   = match_1;
  assign cfg.match_2_out   = match_2;
  assign cfg.match_3_out   = match_3;
  assign cfg.count_out     = count;

  // ------------------------------
  // Raw events
  // ------------------------------
  assign live = counting & ~restart & ~dis;

  assign raw_irq[ttc_irq_pkg::irq_interval] = live & intv & (count == '0);
  assign raw_irq[ttc_irq_pkg::irq_overflow] = live & ~intv & (count == '0);
  assign raw_irq[ttc_irq_pkg::irq_match_1]  = live & match_md & (count == match_1);
  assign raw_irq[ttc_irq_pkg::irq_match_2]  = live & match_md & (count == match_2);
  assign raw_irq[ttc_irq_pkg::irq_match_3]  = live & match_md & (count == match_3);

  // Register writes, restart bit drops after its load
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      cntr_ctrl <= 7'b0000001;  // Disabled out of reset
      interval  <= '0;
      match_1   <= '0;
      match_2   <= '0;
      match_3   <= '0;
    end
    else
    begin
      if (cfg.cntr_ctrl_sel)
        cntr_ctrl <= cfg.wdata[ttc_reg_pkg::ctrl_w-1:0];
      else if (restart_done)
        cntr_ctrl[ttc_reg_pkg::ctrl_restart] <= 1'b0;
      if (cfg.interval_sel)
        interval <= cfg.wdata;
      if (cfg.match_1_sel)
        match_1 <= cfg.wdata;
      if (cfg.match_2_sel)
        match_2 <= cfg.wdata;
      if (cfg.match_3_sel)
        match_3 <= cfg.wdata;
    end
  end

  // ------------------------------
  // Count, steps only on count_en
  // ------------------------------
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      count        <= '0;
      counting     <= 1'b0;
      restart_done <= 1'b0;
    end
    else
    begin
      restart_done <= count_en & restart;  // One cycle only
      if (count_en)
      begin
        if (restart)
        begin
          // Start value depends on direction and mode
          if (!decr)
            count <= '0;
          else if (intv)
            count <= interval;
          else
            count <= '1;
          counting <= 1'b0;
        end
        else if (!dis)
        begin
          if (decr)
            count <= (count == '0) ? (intv ? interval : '1) : count - 1'b1;
          else if (intv)
            count <= (count == interval) ? '0 : count + 1'b1;  // Wrap at interval
          else
            count <= count + 1'b1;  // Natural wrap at FFFF
          counting <= 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/ttc_intr_wave.sv */
// ------------------------------
// Sticky status, enable mask, irq
// line and waveform output
// ------------------------------
module ttc_intr_wave (
  input  logic                          pclk10,
  input  logic                          n_p_reset10,
  input  logic [ttc_irq_pkg::irq_n-1:0] raw_irq,
  input  logic                          status_rd,  // Read clears status
  input  logic                          enable_wr,
  input  logic [ttc_irq_pkg::irq_n-1:0] wdata,
  input  logic                          wave_dis,
  input  logic                          wave_pol,
  output logic [ttc_irq_pkg::irq_n-1:0] intr_status,
  output logic [ttc_irq_pkg::irq_n-1:0] intr_enable,
  output logic                          irq,
  output logic                          wave_out
);

  logic match_ev;  // Match 1 seen
  logic wrap_ev;   // Interval or overflow seen

  assign match_ev = raw_irq[ttc_irq_pkg::irq_match_1];
  assign wrap_ev  = raw_irq[ttc_irq_pkg::irq_interval] | raw_irq[ttc_irq_pkg::irq_overflow];

  // Status and enable registers
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      intr_status <= '0;
      intr_enable <= '0;
    end
    else
    begin
      // New set beats the read clear
      intr_status <= (status_rd ? '0 : intr_status) | raw_irq;
      if (enable_wr)
        intr_enable <= wdata;
    end
  end

  assign irq = |(intr_status & intr_enable);  // Masked line

  // Waveform, match 1 drives polarity, wrap drives inverse
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
      wave_out <= 1'b0;
    else if (wave_dis)
      wave_out <= 1'b0;
    else if (match_ev)
      wave_out <= wave_pol;
    else if (wrap_ev)
      wave_out <= ~wave_pol;
  end

endmodule

/* hdl/ttc_irq_pkg.sv */
// ------------------------------
// Interrupt source count and
// status bit layout
// ------------------------------
package ttc_irq_pkg;

  localparam int irq_n = 5;  // Number of sources

  // Status and enable bit positions
  localparam int irq_interval = 0;
  localparam int irq_match_1  = 1;
  localparam int irq_match_2  = 2;
  localparam int irq_match_3  = 3;
  localparam int irq_overflow = 4;

endpackage

/* hdl/ttc_prescaler.sv */
// ------------------------------
// Prescaler, count enable pulse
// every 2^exp cycles
// ------------------------------
module ttc_prescaler #(
  parameter int prescale_w = 16
) (
  input  logic       pclk10,
  input  logic       n_p_reset10,
  input  logic       clk_en,
  input  logic [3:0] clk_exp,
  input  logic       clk_wr,     // Restarts prescale phase
  output logic       count_en
);

  logic [prescale_w-1:0] pre_cnt;    // Free running
  logic [prescale_w:0]   wrap_bit;   // One hot at exponent
  logic [prescale_w:0]   wrap_mask;  // Low exponent bits set
  logic                  wrap;

  assign wrap_bit  = {{prescale_w{1'b0}}, 1'b1} << clk_exp;
  assign wrap_mask = wrap_bit - 1'b1;

  // Low exponent bits all ones, next step wraps them
  assign wrap = ((pre_cnt & wrap_mask[prescale_w-1:0]) == wrap_mask[prescale_w-1:0]);

  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      pre_cnt  <= '0;
      count_en <= 1'b0;
    end
    else if (clk_wr)
    begin
      pre_cnt  <= '0;     // Phase restarts on every clock control write
      count_en <= 1'b0;
    end
    else
    begin
      pre_cnt  <= pre_cnt + 1'b1;
      count_en <= clk_en & wrap;  // First pulse 2^exp cycles after write
    end
  end

endmodule

/* hdl/ttc_reg_decode.sv */
// ------------------------------
// Bus decode: write strobes, clock
// control register, read data mux
// ------------------------------
module ttc_reg_decode #(
  parameter int prescale_w = 16  // Prescale counter width
) (
  input  logic                                pclk10,
  input  logic                                n_p_reset10,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [7:0]                          paddr,
  input  logic [ttc_reg_pkg::data_w-1:0]      pwdata,
  output logic [ttc_reg_pkg::data_w-1:0]      prdata,
  ttc_cfg_if.decode                           cfg,
  output logic                                clk_en,
  output logic [3:0]                          clk_exp,
  output logic                                clk_wr,
  output logic                                status_rd,
  output logic                                enable_wr,
  input  logic [ttc_irq_pkg::irq_n-1:0]       intr_status,
  input  logic [ttc_irq_pkg::irq_n-1:0]       intr_enable
);

  // Largest exponent the prescaler can honour
  localparam logic [3:0] exp_max = (prescale_w > 15) ? 4'd15 : 4'(prescale_w);

  logic                             wr_acc;  // Access phase write
  logic                             rd_acc;  // Access phase read
  logic [3:0]                       exp_wr;  // Exponent field of pwdata
  logic [ttc_reg_pkg::data_w-1:0]   rd_mux;

  assign wr_acc = psel & penable & pwrite;
  assign rd_acc = psel & penable & ~pwrite;
  assign exp_wr = pwdata[ttc_reg_pkg::clk_exp_lsb +: 4];

  // ------------------------------
  // Write strobes
  // ------------------------------
  assign cfg.wdata         = pwdata;
  assign cfg.cntr_ctrl_sel = wr_acc & (paddr == ttc_reg_pkg::addr_cntr_ctrl);
  assign cfg.interval_sel  = wr_acc & (paddr == ttc_reg_pkg::addr_interval);
  assign cfg.match_1_sel   = wr_acc & (paddr == ttc_reg_pkg::addr_match_1);
  assign cfg.match_2_sel   = wr_acc & (paddr == ttc_reg_pkg::addr_match_2);
  assign cfg.match_3_sel   = wr_acc & (paddr == ttc_reg_pkg::addr_match_3);
  assign clk_wr            = wr_acc & (paddr == ttc_reg_pkg::addr_clk_ctrl);
  assign enable_wr         = wr_acc & (paddr == ttc_reg_pkg::addr_intr_enable);
  assign status_rd         = rd_acc & (paddr == ttc_reg_pkg::addr_intr_status);

  // Clock control register, exponent clamped on write
  always_ff @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      clk_en  <= 1'b0;
      clk_exp <= 4'd0;
    end
    else if (clk_wr)
    begin
      clk_en  <= pwdata[ttc_reg_pkg::clk_en];
      clk_exp <= (exp_wr > exp_max) ? exp_max : exp_wr;
    end
  end

  // ------------------------------
  // Read data mux
  // ------------------------------
  always_comb
  begin
    rd_mux = '0;
    case (paddr)
      ttc_reg_pkg::addr_clk_ctrl:
      begin
        rd_mux[ttc_reg_pkg::clk_en]             = clk_en;
        rd_mux[ttc_reg_pkg::clk_exp_lsb +: 4]   = clk_exp;
      end
      ttc_reg_pkg::addr_cntr_ctrl:   rd_mux = ttc_reg_pkg::data_w'(cfg.cntr_ctrl_out);
      ttc_reg_pkg::addr_count:       rd_mux = cfg.count_out;
      ttc_reg_pkg::addr_interval:    rd_mux = cfg.interval_out;
      ttc_reg_pkg::addr_match_1:     rd_mux = cfg.match_1_out;
      ttc_reg_pkg::addr_match_2:     rd_mux = cfg.match_2_out;
      ttc_reg_pkg::addr_match_3:     rd_mux = cfg.match_3_out;
      ttc_reg_pkg::addr_intr_status: rd_mux = ttc_reg_pkg::data_w'(intr_status);
      ttc_reg_pkg::addr_intr_enable: rd_mux = ttc_reg_pkg::data_w'(intr_enable);
      default:                       rd_mux = '0;  // Unmapped reads as 0
    endcase
  end

  assign prdata = rd_acc ? rd_mux : '0;  // Only during access phase

endmodule

/* hdl/ttc_reg_pkg.sv */
// ------------------------------
// Timer register map, bus and
// control widths, control bit fields
// ------------------------------
package ttc_reg_pkg;

  // Byte offsets of the timer registers
  localparam logic [7:0] addr_clk_ctrl    = 8'h00;
  localparam logic [7:0] addr_cntr_ctrl   = 8'h04;
  localparam logic [7:0] addr_count       = 8'h08;  // Read only
  localparam logic [7:0] addr_interval    = 8'h0C;
  localparam logic [7:0] addr_match_1     = 8'h10;
  localparam logic [7:0] addr_match_2     = 8'h14;
  localparam logic [7:0] addr_match_3     = 8'h18;
  localparam logic [7:0] addr_intr_status = 8'h1C;  // Read clears
  localparam logic [7:0] addr_intr_enable = 8'h20;

  localparam int data_w = 16;  // Bus data width
  localparam int ctrl_w = 7;   // Counter control width

  // Counter control bits
  localparam int ctrl_dis      = 0;  // Disable, active high
  localparam int ctrl_interval = 1;  // Interval mode, else overflow
  localparam int ctrl_decr     = 2;  // Count down
  localparam int ctrl_match    = 3;  // Match mode
  localparam int ctrl_restart  = 4;  // Self clearing
  localparam int ctrl_wave_dis = 5;
  localparam int ctrl_wave_pol = 6;

  // Clock control bits
  localparam int clk_en      = 0;
  localparam int clk_exp_lsb = 1;  // 4 bit prescale exponent

endpackage

/* hdl/ttc_timer_top.sv */
// ------------------------------
// Timer channel top: decode,
// prescaler, counter, irq stage
// ------------------------------
module ttc_timer_top #(
  parameter int prescale_w = 16
) (
  input  logic        pclk10,
  input  logic        n_p_reset10,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [15:0] pwdata,
  output logic [15:0] prdata,
  output logic        irq,
  output logic        wave_out
);

  ttc_cfg_if cfg ();  // Decode to counter

  logic                          clk_en;
  logic [3:0]                    clk_exp;
  logic                          clk_wr;
  logic                          count_en;
  logic                          status_rd;
  logic                          enable_wr;
  logic                          wave_dis;
  logic                          wave_pol;
  logic [ttc_irq_pkg::irq_n-1:0] raw_irq;
  logic [ttc_irq_pkg::irq_n-1:0] intr_status;
  logic [ttc_irq_pkg::irq_n-1:0] intr_enable;

  ttc_reg_decode #(.prescale_w(prescale_w)) i_decode (
    .pclk10, .n_p_reset10,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .cfg         (cfg.decode),
    .clk_en, .clk_exp, .clk_wr,
    .status_rd, .enable_wr,
    .intr_status, .intr_enable
  );

  ttc_prescaler #(.prescale_w(prescale_w)) i_prescaler (
    .pclk10, .n_p_reset10,
    .clk_en, .clk_exp, .clk_wr,
    .count_en
  );

  ttc_counter_lite i_counter (
    .pclk10, .n_p_reset10,
    .cfg         (cfg.counter),
    .count_en, .raw_irq, .wave_dis, .wave_pol
  );

  ttc_intr_wave i_intr_wave (
    .pclk10, .n_p_reset10,
    .raw_irq, .status_rd, .enable_wr,
    .wdata       (pwdata[ttc_irq_pkg::irq_n-1:0]),  // Enable mask bits
    .wave_dis, .wave_pol,
    .intr_status, .intr_enable,
    .irq, .wave_out
  );

endmodule

/* project.f */
hdl/ttc_reg_pkg.sv
hdl/ttc_irq_pkg.sv
hdl/ttc_cfg_if.sv
hdl/ttc_reg_decode.sv
hdl/ttc_prescaler.sv
hdl/ttc_counter_lite.sv
hdl/ttc_intr_wave.sv
hdl/ttc_timer_top.sv
tb/ttc_timer_checker.sv
tb/ttc_timer_tb.sv

/* tb/ttc_timer_checker.sv */
// ------------------------------
// Timer reference model, bus and
// pin comparisons, per test lines
// ------------------------------
module ttc_timer_checker (
  input  logic        pclk10,
  input  logic        n_p_reset10,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [15:0] pwdata,
  input  logic [15:0] prdata,
  input  logic        irq,
  input  logic        wave_out,
  input  logic [79:0] test_name,
  input  logic        test_done,   // Pulse at the end of each test
  output logic [31:0] err_cnt,
  output logic [31:0] chk_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // Model state
  // ------------------------------
  logic        m_clk_en;
  logic [3:0]  m_exp;
  logic [6:0]  m_ctrl;
  logic [15:0] m_intv;
  logic [15:0] m_m1;
  logic [15:0] m_m2;
  logic [15:0] m_m3;
  logic [15:0] m_count;
  logic [4:0]  m_stat;
  logic [4:0]  m_enab;
  logic        m_cen;     // Modelled count enable level
  logic        m_run;     // Steps taken since restart
  logic        m_rdone;   // Restart load seen last edge
  logic        m_wave;
  int          m_phase;   // Edges since clock control write
  logic [4:0]  ev;
  logic        live;
  logic        clr_rst;
  logic        wr;
  logic        rd;
  logic [31:0] t_err;
  logic [31:0] t_chk;

  task check_val(input logic [63:0] what, input logic [15:0] expv, input logic [15:0] actv);
    chk_cnt = chk_cnt + 1;
    t_chk   = t_chk + 1;
    if (actv !== expv)
    begin
      err_cnt = err_cnt + 1;
      t_err   = t_err + 1;
      $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expv, actv);
    end
  endtask

  always @(posedge pclk10 or negedge n_p_reset10)
  begin
    if (!n_p_reset10)
    begin
      m_clk_en = 1'b0;
      m_exp    = 4'd0;
      m_ctrl   = 7'b0000001;  // Counter disabled
      m_intv   = 16'h0;
      m_m1     = 16'h0;
      m_m2     = 16'h0;
      m_m3     = 16'h0;
      m_count  = 16'h0;
      m_stat   = 5'h0;
      m_enab   = 5'h0;
      m_cen    = 1'b0;
      m_run    = 1'b0;
      m_rdone  = 1'b0;
      m_wave   = 1'b0;
      m_phase  = 0;
    end
    else
    begin
      if (test_done)
      begin
        $display("%s: %0d checks, %0d errors", test_name, t_chk, t_err);
        t_err = 0;
        t_chk = 0;
      end
      wr = psel & penable & pwrite;
      rd = psel & penable & ~pwrite;

      // Pins and read data before this edge
      check_val("irq", 16'(|(m_stat & m_enab)), 16'(irq));
      check_val("wave_out", 16'(m_wave), 16'(wave_out));
      if (rd)
        case (paddr)
          ttc_reg_pkg::addr_count:       check_val("count", m_count, prdata);
          ttc_reg_pkg::addr_interval:    check_val("interval", m_intv, prdata);
          ttc_reg_pkg::addr_match_1:     check_val("match_1", m_m1, prdata);
          ttc_reg_pkg::addr_match_2:     check_val("match_2", m_m2, prdata);
          ttc_reg_pkg::addr_match_3:     check_val("match_3", m_m3, prdata);
          ttc_reg_pkg::addr_intr_status: check_val("status", 16'(m_stat), prdata);
          ttc_reg_pkg::addr_intr_enable: check_val("enable", 16'(m_enab), prdata);
          default: ;
        endcase

      // Events seen on the current count
      live = m_run & ~m_ctrl[ttc_reg_pkg::ctrl_restart] & ~m_ctrl[ttc_reg_pkg::ctrl_dis];
      ev   = 5'h0;
      ev[ttc_irq_pkg::irq_interval] = live & m_ctrl[ttc_reg_pkg::ctrl_interval] & (m_count == 0);
      ev[ttc_irq_pkg::irq_overflow] = live & ~m_ctrl[ttc_reg_pkg::ctrl_interval] & (m_count == 0);
      ev[ttc_irq_pkg::irq_match_1]  = live & m_ctrl[ttc_reg_pkg::ctrl_match] & (m_count == m_m1);
      ev[ttc_irq_pkg::irq_match_2]  = live & m_ctrl[ttc_reg_pkg::ctrl_match] & (m_count == m_m2);
      ev[ttc_irq_pkg::irq_match_3]  = live & m_ctrl[ttc_reg_pkg::ctrl_match] & (m_count == m_m3);
      m_stat = ((rd && paddr == ttc_reg_pkg::addr_intr_status) ? 5'h0 : m_stat) | ev;  // Set wins
      if (m_ctrl[ttc_reg_pkg::ctrl_wave_dis])
        m_wave = 1'b0;
      else if (ev[ttc_irq_pkg::irq_match_1])
        m_wave = m_ctrl[ttc_reg_pkg::ctrl_wave_pol];
      else if (ev[ttc_irq_pkg::irq_interval] | ev[ttc_irq_pkg::irq_overflow])
        m_wave = ~m_ctrl[ttc_reg_pkg::ctrl_wave_pol];

      // Count step on a tick
      clr_rst = m_rdone;
      m_rdone = m_cen & m_ctrl[ttc_reg_pkg::ctrl_restart];
      if (m_cen && m_ctrl[ttc_reg_pkg::ctrl_restart])
      begin
        if (!m_ctrl[ttc_reg_pkg::ctrl_decr])
          m_count = 16'h0;
        else if (m_ctrl[ttc_reg_pkg::ctrl_interval])
          m_count = m_intv;
        else
          m_count = 16'hFFFF;
        m_run = 1'b0;
      end
      else if (m_cen && !m_ctrl[ttc_reg_pkg::ctrl_dis])
      begin
        if (m_ctrl[ttc_reg_pkg::ctrl_decr])
          m_count = (m_count != 0) ? m_count - 1 :
                    (m_ctrl[ttc_reg_pkg::ctrl_interval] ? m_intv : 16'hFFFF);
        else if (m_ctrl[ttc_reg_pkg::ctrl_interval] && m_count == m_intv)
          m_count = 16'h0;  // Interval wrap
        else
          m_count = m_count + 1;
        m_run = 1'b1;
      end

      // Tick every 2^exp edges after a clock control write
      if (wr && paddr == ttc_reg_pkg::addr_clk_ctrl)
      begin
        m_phase = 0;
        m_cen   = 1'b0;
      end
      else
      begin
        m_phase = m_phase + 1;
        m_cen   = m_clk_en && (m_phase % (1 << m_exp) == 0);
      end

      if (wr)
        case (paddr)
          ttc_reg_pkg::addr_clk_ctrl:
          begin
            m_clk_en = pwdata[ttc_reg_pkg::clk_en];
            m_exp    = pwdata[ttc_reg_pkg::clk_exp_lsb +: 4];
          end
          ttc_reg_pkg::addr_cntr_ctrl:   m_ctrl = pwdata[6:0];
          ttc_reg_pkg::addr_interval:    m_intv = pwdata;
          ttc_reg_pkg::addr_match_1:     m_m1   = pwdata;
          ttc_reg_pkg::addr_match_2:     m_m2   = pwdata;
          ttc_reg_pkg::addr_match_3:     m_m3   = pwdata;
          ttc_reg_pkg::addr_intr_enable: m_enab = pwdata[4:0];
          default: ;
        endcase
      if (clr_rst && !(wr && paddr == ttc_reg_pkg::addr_cntr_ctrl))
        m_ctrl[ttc_reg_pkg::ctrl_restart] = 1'b0;  // Restart bit self clears
    end
  end

  initial
  begin
    err_cnt = 0;
    chk_cnt = 0;
    t_err   = 0;
    t_chk   = 0;
  end

endmodule

/* tb/ttc_timer_tb.sv */
// ------------------------------
// Timer testbench with clock,
// reset, stimulus table, bus tasks
// ------------------------------
module ttc_timer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_tests      = 10;
  localparam int reset_cycles = 8;

  // One table row per test
  typedef struct packed {
    logic [79:0] name;
    logic        clk_en;
    logic [3:0]  exp;
    logic [6:0]  ctrl;
    logic [15:0] intv;
    logic [15:0] m1;
    logic [15:0] m2;
    logic [15:0] m3;
    logic [4:0]  enab;
    logic [15:0] run;   // Cycles with the counter enabled
  } entry_t;

  entry_t      tests [n_tests];
  logic        pclk10;
  logic        n_p_reset10;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        irq;
  logic        wave_out;
  logic [79:0] test_name;
  logic        test_done;
  logic [31:0] err_cnt;
  logic [31:0] chk_cnt;
  integer      seed;
  int          cycles = 0;
  int          limit;

  ttc_timer_top #(.prescale_w(16)) i_dut (
    .pclk10, .n_p_reset10,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .irq, .wave_out
  );

  ttc_timer_checker i_checker (
    .pclk10, .n_p_reset10,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
    .irq, .wave_out,
    .test_name, .test_done,
    .err_cnt, .chk_cnt
  );

  initial
  begin
    pclk10 = 1'b0;
    forever #2 pclk10 = ~pclk10;  // 4 ns period
  end

  // Hang guard
  always @(posedge pclk10)
  begin
    cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("Timeout: run did not end within %0d cycles", limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic [15:0] rand_range(input int lo, input int span);
    return 16'(lo + ($unsigned($random(seed)) % span));
  endfunction

  task fill_entry(input int i, input logic [79:0] name, input logic en, input logic [3:0] exp,
                  input logic [6:0] ctrl, input logic [15:0] intv, input logic [15:0] m1,
                  input logic [15:0] m2, input logic [15:0] m3, input logic [4:0] enab,
                  input logic [15:0] run);
    tests[i] = {name, en, exp, ctrl, intv, m1, m2, m3, enab, run};
  endtask

  // ------------------------------
  // Bus tasks with setup then access phase
  // ------------------------------
  task bus_access(input logic wr, input logic [7:0] a, input logic [15:0] d);
    @(posedge pclk10);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    @(posedge pclk10);
    penable <= 1'b1;
  endtask

  task bus_write(input logic [7:0] a, input logic [15:0] d);
    bus_access(1'b1, a, d);
  endtask

  task bus_read(input logic [7:0] a);
    bus_access(1'b0, a, 16'h0);  // Write data ignored on a read
  endtask

  task bus_idle;
    @(posedge pclk10);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task end_test;
    @(posedge pclk10);
    test_done <= 1'b1;
    @(posedge pclk10);
    test_done <= 1'b0;
  endtask

  // Program the registers, run, stop and read back
  task run_entry(input entry_t t);
    test_name <= t.name;
    bus_write(ttc_reg_pkg::addr_interval, t.intv);
    bus_write(ttc_reg_pkg::addr_match_1, t.m1);
    bus_write(ttc_reg_pkg::addr_match_2, t.m2);
    bus_write(ttc_reg_pkg::addr_match_3, t.m3);
    bus_write(ttc_reg_pkg::addr_intr_enable, 16'(t.enab));
    bus_write(ttc_reg_pkg::addr_clk_ctrl, {11'h0, t.exp, t.clk_en});
    bus_write(ttc_reg_pkg::addr_cntr_ctrl, 16'(t.ctrl));
    bus_idle;
    repeat (t.run) @(posedge pclk10);
    bus_write(ttc_reg_pkg::addr_cntr_ctrl, 16'((t.ctrl & 7'h6F) | 7'h01));  // Stop
    bus_read(ttc_reg_pkg::addr_interval);
    bus_read(ttc_reg_pkg::addr_match_1);
    bus_read(ttc_reg_pkg::addr_match_2);
    bus_read(ttc_reg_pkg::addr_match_3);
    bus_read(ttc_reg_pkg::addr_intr_enable);
    bus_read(ttc_reg_pkg::addr_count);
    bus_read(ttc_reg_pkg::addr_intr_status);
    bus_read(ttc_reg_pkg::addr_intr_status);  // Second read sees cleared status
    bus_idle;
    end_test;
  endtask

  initial
  begin
    seed        = 32'hd4a8;
    n_p_reset10 = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 8'h0;
    pwdata      = 16'h0;
    test_done   = 1'b0;
    test_name   = "reset";

    // name, en, exp, ctrl, interval, match 1..3, enable, run
    fill_entry(0, "ovf_up", 1, 0, 7'h10, rand_range(8, 16), 16'h0, 16'h0, 16'h0, 5'h10, 50);
    // Down from the last count through 0
    fill_entry(1, "ovf_wrap", 1, 0, 7'h04, 16'h0, 16'h0, 16'h0, 16'h0, 5'h10, 60);
    fill_entry(2, "ovf_down", 1, 0, 7'h14, 16'h0, 16'h0, 16'h0, 16'h0, 5'h10, 40);
    fill_entry(3, "intv_up", 1, 0, 7'h12, rand_range(8, 16), 16'h0, 16'h0, 16'h0, 5'h01, 60);
    fill_entry(4, "intv_down", 1, 0, 7'h56, rand_range(8, 16), 16'h0, 16'h0, 16'h0, 5'h01, 50);
    fill_entry(5, "match", 1, 0, 7'h58, 16'h0, rand_range(4, 12), rand_range(16, 16), 16'h4000,
               5'h0E, 40);
    fill_entry(6, "match_wdis", 1, 0, 7'h38, 16'h0, rand_range(4, 12), rand_range(12, 10),
               rand_range(60, 20), 5'h02, 45);
    fill_entry(7, "presc_e2", 1, 2, 7'h10, 16'h0, 16'h0, 16'h0, 16'h0, 5'h00, 64);
    fill_entry(8, "presc_e3", 1, 3, 7'h14, 16'h0, 16'h0, 16'h0, 16'h0, 5'h1F, 80);
    fill_entry(9, "clk_off", 0, 0, 7'h10, 16'h0, 16'h0, 16'h0, 16'h0, 5'h00, 30);

    limit = reset_cycles + 40;  // Reset and first reads
    for (int i = 0; i < n_tests; i++)
      limit = limit + tests[i].run + 40;

    repeat (reset_cycles) @(posedge pclk10);
    n_p_reset10 <= 1'b1;

    bus_read(ttc_reg_pkg::addr_count);  // Count is 0 after reset
    bus_read(ttc_reg_pkg::addr_intr_status);
    bus_idle;
    end_test;
    for (int i = 0; i < n_tests; i++)
      run_entry(tests[i]);

    repeat (2) @(posedge pclk10);
    @(negedge pclk10);  // Counts settled
    $display("Tests: %0d, checks: %0d, errors: %0d", n_tests + 1, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
